//--- filelist.f
readout_pkg.sv
gate_posedge_clk.sv
latch_fifo.sv
readout_merger.sv
uart_tx_serializer.sv
readout_top.sv
readout_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module readout_tb -f filelist.f -o sim_readout

# the simulator exits nonzero on a failure, the log decides
./obj_dir/sim_readout > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    exit 1
fi

//--- readout_tb.sv
/*
 * readout testbench
 * drives hit and config strobes into the readout top, decodes the tx
 * line and checks framing, parity, per-stream order, config priority,
 * data FIFO flags and overflow drops against its own scoreboards
 */

`timescale 1ns/1ps

module readout_tb import readout_pkg::*; ();

    localparam int          MAX_WORDS      = 107;  // 2 single + 6 paired + 19 burst + 80 random
    localparam int          TIMEOUT_CYCLES = MAX_WORDS * FRAME_BITS + 2000;
    localparam logic [31:0] SEED           = 32'hc2d22eb4;

    logic                     clk;
    logic                     reset_n;
    logic                     hit_write_n;
    logic [5:0]               hit_channel;
    logic [31:0]              hit_timestamp;
    logic [7:0]               hit_adc;
    logic                     cfg_write_n;
    logic [7:0]               cfg_addr;
    logic [7:0]               cfg_value;
    logic [7:0]               chip_id;
    logic                     tx;
    logic                     data_fifo_full;
    logic                     data_fifo_half;
    logic [DATA_CNT_BITS-1:0] data_fifo_counter;
    logic                     config_fifo_full;

    // scoreboards hold expected payloads already padded to 52 bits
    logic [PAYLOAD_BITS-1:0] data_q[$];
    logic [PAYLOAD_BITS-1:0] cfg_q[$];
    int          hit_accepted   = 0;
    int          cfg_accepted   = 0;
    int          hits_dropped   = 0;
    int          cfg_dropped    = 0;
    int          data_frames    = 0;   // data frames started with one pop each
    int          frames_started = 0;   // start bits seen on tx
    int          frames_done    = 0;
    int          post_reset     = 0;
    int          cycle_count    = 0;
    int          priority_req   = 0;   // bumped by the driver per paired write
    int          priority_seen  = 0;
    int          rx_state       = 0;   // 0 idle, 1 data bits, 2 stop bit
    logic [5:0]  bit_idx;
    logic [63:0] frame;
    logic        frame_active   = 1'b0;

    readout_top readout_i (
        .clk               (clk),
        .reset_n           (reset_n),
        .hit_write_n       (hit_write_n),
        .hit_channel       (hit_channel),
        .hit_timestamp     (hit_timestamp),
        .hit_adc           (hit_adc),
        .cfg_write_n       (cfg_write_n),
        .cfg_addr          (cfg_addr),
        .cfg_value         (cfg_value),
        .chip_id           (chip_id),
        .tx                (tx),
        .data_fifo_full    (data_fifo_full),
        .data_fifo_half    (data_fifo_half),
        .data_fifo_counter (data_fifo_counter),
        .config_fifo_full  (config_fifo_full)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    ////////////////////////////////////////////////////////////
    // checking helpers
    ////////////////////////////////////////////////////////////

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
        assert (actual === expected)
        else fail_run($sformatf("[ERROR] time %0t: %s expected %0h, actual %0h",
                                $time, name, expected, actual));
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else fail_run(what);
    endtask

    // counter must equal accepted writes minus pops and flags follow at 4 and 8
    task automatic check_flags();
        int exp_count;
        exp_count = hit_accepted - data_frames;
        check_eq("data_fifo_counter", 64'(exp_count), 64'(data_fifo_counter));
        check_eq("data_fifo_half", 64'(exp_count >= DATA_FIFO_DEPTH / 2), 64'(data_fifo_half));
        check_eq("data_fifo_full", 64'(exp_count == DATA_FIFO_DEPTH), 64'(data_fifo_full));
    endtask

    task automatic check_frame();
        logic [PAYLOAD_BITS-1:0] expected;
        check_eq("tx frame weight odd", 64'd1, 64'($countones(frame) % 2));
        check_eq("tx reserved bit", 64'd0, 64'(frame[62]));
        check_eq("tx chip_id field", 64'(chip_id), 64'(frame[9:2]));
        if (priority_seen != priority_req) begin
            check_eq("tx pkt_type after paired write", 64'(PKT_CONFIG), 64'(frame[1:0]));
            priority_seen = priority_req;
        end
        if (frame[1:0] == PKT_CONFIG) begin
            check_true(cfg_q.size() > 0, "config frame sent with no config reply outstanding");
            expected = cfg_q.pop_front();
            check_eq("tx config payload", 64'(expected), 64'(frame[61:10]));
        end else if (frame[1:0] == PKT_DATA) begin
            check_true(data_q.size() > 0, "data frame sent with no hit outstanding");
            expected = data_q.pop_front();
            check_eq("tx data payload", 64'(expected), 64'(frame[61:10]));
        end else begin
            fail_run("tx frame carries an unknown packet type");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // tx decoder and write monitor sample mid cycle
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!reset_n || post_reset < 3) begin   // reset state and just after
            check_eq("tx", 64'd1, 64'(tx));
            check_eq("data_fifo_full", 64'd0, 64'(data_fifo_full));
            check_eq("config_fifo_full", 64'd0, 64'(config_fifo_full));
            check_eq("data_fifo_counter", 64'd0, 64'(data_fifo_counter));
        end
        if (reset_n) begin
            post_reset++;
            case (rx_state)
                0: if (tx == 1'b0) begin        // start bit
                    rx_state     = 1;
                    bit_idx      = '0;
                    frame_active = 1'b1;
                    frames_started++;
                end
                1: begin
                    frame[bit_idx] = tx;
                    if (bit_idx == 6'd1 && {tx, frame[0]} == PKT_DATA) begin
                        data_frames++;          // its pop is already in the counter
                    end
                    if (bit_idx >= 6'd2) begin
                        check_flags();          // no pops while the line is busy
                    end
                    if (bit_idx == 6'd63) rx_state = 2;
                    else bit_idx = bit_idx + 6'd1;
                end
                default: begin
                    check_eq("tx stop bit", 64'd1, 64'(tx));
                    check_frame();
                    rx_state     = 0;
                    frame_active = 1'b0;
                    frames_done++;
                end
            endcase
            // strobes are counted after the flag check as they land at the next edge
            if (!hit_write_n) begin
                if (!data_fifo_full) begin
                    data_q.push_back(PAYLOAD_BITS'({hit_channel, hit_timestamp, hit_adc}));
                    hit_accepted++;
                end else hits_dropped++;
            end
            if (!cfg_write_n) begin
                if (!config_fifo_full) begin
                    cfg_q.push_back(PAYLOAD_BITS'({cfg_addr, cfg_value}));
                    cfg_accepted++;
                end else cfg_dropped++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            fail_run("timeout: tx frames did not drain within the cycle limit");
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    // one strobe cycle with fresh random fields and then one quiet cycle
    task automatic write_words(input logic do_hit, input logic do_cfg);
        hit_write_n   <= !do_hit;
        cfg_write_n   <= !do_cfg;
        hit_channel   <= 6'($urandom);
        hit_timestamp <= 32'($urandom);
        hit_adc       <= 8'($urandom);
        cfg_addr      <= 8'($urandom);
        cfg_value     <= 8'($urandom);
        @(posedge clk);
        hit_write_n <= 1'b1;
        cfg_write_n <= 1'b1;
        @(posedge clk);
    endtask

    task automatic drain();
        while (frames_done != hit_accepted + cfg_accepted) @(posedge clk);
        repeat (4) @(posedge clk);   // merger back in idle
    endtask

    initial begin
        void'($urandom(SEED));
        reset_n       = 1'b0;
        hit_write_n   = 1'b1;
        cfg_write_n   = 1'b1;
        hit_channel   = '0;
        hit_timestamp = '0;
        hit_adc       = '0;
        cfg_addr      = '0;
        cfg_value     = '0;
        chip_id       = 8'($urandom);
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
        repeat (6) @(posedge clk);

        write_words(1'b1, 1'b0);      // lone hit
        drain();
        write_words(1'b0, 1'b1);      // lone config reply
        drain();

        repeat (3) begin              // paired writes on an idle line
            priority_req++;
            write_words(1'b1, 1'b1);
            drain();
        end

        // overflow burst behind a frame in flight
        write_words(1'b0, 1'b1);
        while (!frame_active) @(posedge clk);
        for (int i = 0; i < 12; i++) write_words(1'b1, i < 6);
        drain();
        check_true(hits_dropped > 0, "hit burst overflowed no words");
        check_true(cfg_dropped > 0, "config burst overflowed no words");

        repeat (40) write_words(($urandom % 4) == 0, ($urandom % 8) == 0);
        drain();
        repeat (100) @(posedge clk);  // any extra frame would show up here

        check_eq("frames sent", 64'(hit_accepted + cfg_accepted), 64'(frames_started));
        check_eq("data_fifo_counter", 64'd0, 64'(data_fifo_counter));
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- readout_top.sv
/*
 * pixel readout top
 * hit words and config replies each go to their own latch FIFO; the
 * merger pops them config first and the serializer sends each word
 * out on a single tx line
 */

`timescale 1ns/1ps

module readout_top import readout_pkg::*; (
    input  logic                     clk,
    input  logic                     reset_n,
    // hit stream
    input  logic                     hit_write_n,
    input  logic [5:0]               hit_channel,
    input  logic [31:0]              hit_timestamp,
    input  logic [7:0]               hit_adc,
    // config read replies
    input  logic                     cfg_write_n,
    input  logic [7:0]               cfg_addr,
    input  logic [7:0]               cfg_value,
    input  logic [7:0]               chip_id,     // static
    output logic                     tx,
    output logic                     data_fifo_full,
    output logic                     data_fifo_half,
    output logic [DATA_CNT_BITS-1:0] data_fifo_counter,
    output logic                     config_fifo_full
);

    data_hit_t     hit_word;          // packed chip-side hit
    data_hit_t     data_out;          // data fifo output latch
    config_reply_t cfg_word;
    config_reply_t cfg_out;
    logic          data_empty;
    logic          config_empty;
    logic          data_read_n;
    logic          config_read_n;
    logic          tx_busy;
    logic          tx_load;
    tx_word_t      tx_word;

    assign hit_word.channel_id = hit_channel;
    assign hit_word.timestamp  = hit_timestamp;
    assign hit_word.adc        = hit_adc;
    assign cfg_word.reg_addr   = cfg_addr;
    assign cfg_word.reg_value  = cfg_value;

    ////////////////////////////////////////////////////////////
    // fifos
    ////////////////////////////////////////////////////////////

    latch_fifo #(
        .payload_t (data_hit_t),
        .DEPTH     (DATA_FIFO_DEPTH)
    ) data_fifo_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .write_n      (hit_write_n),
        .read_n       (data_read_n),
        .data_in      (hit_word),
        .data_out     (data_out),
        .fifo_counter (data_fifo_counter),
        .fifo_full    (data_fifo_full),
        .fifo_half    (data_fifo_half),
        .fifo_empty   (data_empty)
    );

    latch_fifo #(
        .payload_t (config_reply_t),
        .DEPTH     (CONFIG_FIFO_DEPTH)
    ) config_fifo_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .write_n      (cfg_write_n),
        .read_n       (config_read_n),
        .data_in      (cfg_word),
        .data_out     (cfg_out),
        .fifo_counter (),               // only the full flag leaves the chip
        .fifo_full    (config_fifo_full),
        .fifo_half    (),
        .fifo_empty   (config_empty)
    );

    ////////////////////////////////////////////////////////////
    // merge and send
    ////////////////////////////////////////////////////////////

    readout_merger merger_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .chip_id       (chip_id),
        .data_empty    (data_empty),
        .data_word     (data_out),
        .data_read_n   (data_read_n),
        .config_empty  (config_empty),
        .config_word   (cfg_out),
        .config_read_n (config_read_n),
        .tx_busy       (tx_busy),
        .tx_load       (tx_load),
        .tx_word       (tx_word)
    );

    uart_tx_serializer serializer_i (
        .clk     (clk),
        .reset_n (reset_n),
        .load    (tx_load),
        .word    (tx_word),
        .tx      (tx),
        .busy    (tx_busy)
    );

endmodule

//--- uart_tx_serializer.sv
/*
 * uart style serializer
 * frames a 64-bit word with a start bit of 0 and a stop bit of 1 and
 * shifts it out lsb first, one bit per clock, with a busy level
 */

`timescale 1ns/1ps

module uart_tx_serializer import readout_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     load,      // one cycle pulse, ignored while busy
    input  tx_word_t word,
    output logic     tx,
    output logic     busy
);

    logic [FRAME_BITS-1:0]     shift_q;     // bit 0 is on the line
    logic [FRAME_CNT_BITS-1:0] bit_cnt_q;   // bits left after the current one

    ////////////////////////////////////////////////////////////
    // frame shifter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            shift_q   <= '1;                // line idles high
            bit_cnt_q <= '0;
            busy      <= 1'b0;
        end else if (load && !busy) begin
            shift_q   <= {1'b1, word, 1'b0};   // stop, data, start
            bit_cnt_q <= FRAME_CNT_BITS'(FRAME_BITS - 1);
            busy      <= 1'b1;
        end else if (busy) begin
            shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};  // refill with idle level
            if (bit_cnt_q == '0) begin
                busy <= 1'b0;               // stop bit has had its cycle
            end else begin
                bit_cnt_q <= bit_cnt_q - 1'b1;
            end
        end
    end

    assign tx = shift_q[0];

endmodule

//--- readout_merger.sv
/*
 * readout merger
 * pops the configuration FIFO ahead of the hit FIFO whenever the
 * serializer is idle, then builds the 64-bit tx word with type code,
 * chip id, zero padded payload and odd parity
 */

`timescale 1ns/1ps

module readout_merger import readout_pkg::*; (
    input  logic          clk,
    input  logic          reset_n,
    input  logic [7:0]    chip_id,
    input  logic          data_empty,
    input  data_hit_t     data_word,
    output logic          data_read_n,
    input  logic          config_empty,
    input  config_reply_t config_word,
    output logic          config_read_n,
    input  logic          tx_busy,
    output logic          tx_load,
    output tx_word_t      tx_word
);

    typedef enum logic [1:0] {
        ST_IDLE,     // wait for a word and a free line
        ST_FETCH,    // fifo output latch settles
        ST_LOAD      // hand the word to the serializer
    } state_t;

    state_t   state_q;
    state_t   state_d;
    logic     src_cfg_q;      // 1 when the popped word is a config reply
    logic     pop;            // a fifo gets popped this cycle
    tx_word_t word_d;
    tx_word_t word_q;

    ////////////////////////////////////////////////////////////
    // source select and fsm
    ////////////////////////////////////////////////////////////

    assign pop = (state_q == ST_IDLE) && !tx_busy && !(config_empty && data_empty);

    // config replies always win
    assign config_read_n = !(pop && !config_empty);
    assign data_read_n   = !(pop && config_empty);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:  if (pop) state_d = ST_FETCH;
            ST_FETCH: state_d = ST_LOAD;
            ST_LOAD:  state_d = ST_IDLE;   // busy shows up next edge
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q   <= ST_IDLE;
            src_cfg_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (pop) begin
                src_cfg_q <= !config_empty;   // remember which fifo was popped
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // word build
    ////////////////////////////////////////////////////////////

    always_comb begin
        word_d          = '0;               // padding and reserved bit stay 0
        word_d.chip_id  = chip_id;
        if (src_cfg_q) begin
            word_d.pkt_type                              = PKT_CONFIG;
            word_d.payload[$bits(config_reply_t)-1:0]    = config_word;
        end else begin
            word_d.pkt_type                              = PKT_DATA;
            word_d.payload[$bits(data_hit_t)-1:0]        = data_word;
        end
        word_d.parity = ~^word_d;           // parity bit is 0 here, so this gives odd weight
    end

    // data_out is stable by the end of the fetch cycle
    always_ff @(posedge clk) begin
        if (state_q == ST_FETCH) begin
            word_q <= word_d;
        end
    end

    assign tx_load = (state_q == ST_LOAD);
    assign tx_word = word_q;

endmodule

//--- latch_fifo.sv
/*
 * strobe driven FIFO with latch storage
 * active low read and write strobes, writes dropped when full and reads
 * ignored when empty. the write word is staged in a flop and copied into
 * the latch array on a gated clock pulse; data_out is a latch opened by
 * a second gated pulse. flags and word count come from the pointers
 */

`timescale 1ns/1ps

module latch_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        write_n,       // one cycle low per word
    input  logic                        read_n,        // one cycle low per word
    input  payload_t                    data_in,
    output payload_t                    data_out,      // held until the next read
    output logic [$clog2(DEPTH):0]      fifo_counter,  // words stored, 0..DEPTH
    output logic                        fifo_full,
    output logic                        fifo_half,
    output logic                        fifo_empty
);

    localparam int ADDR_BITS = $clog2(DEPTH);
    localparam int CNT_BITS  = ADDR_BITS + 1;

    payload_t mem [DEPTH];              // latch array

    logic [ADDR_BITS-1:0] wr_addr;      // next row to write
    logic [ADDR_BITS-1:0] rd_addr;      // next row to read
    logic                 wr_wrap;      // toggles each pass through the array
    logic                 rd_wrap;

    logic                 wr_en;        // accepted write
    logic                 rd_en;        // accepted read
    logic                 wr_gclk;      // pulse that opens one storage row
    logic                 rd_gclk;      // pulse that opens data_out

    payload_t             wr_data_q;    // staging register
    logic [ADDR_BITS-1:0] wr_row_q;
    logic [ADDR_BITS-1:0] rd_row_q;

    assign wr_en = !write_n && !fifo_full;   // silent drop when full
    assign rd_en = !read_n && !fifo_empty;   // nothing to pop when empty

    ////////////////////////////////////////////////////////////
    // pointers, modulo DEPTH with a wrap bit
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_addr <= '0;
            wr_wrap <= 1'b0;
        end else if (wr_en) begin
            if (wr_addr == ADDR_BITS'(DEPTH - 1)) begin
                wr_addr <= '0;
                wr_wrap <= ~wr_wrap;
            end else begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_addr <= '0;
            rd_wrap <= 1'b0;
        end else if (rd_en) begin
            if (rd_addr == ADDR_BITS'(DEPTH - 1)) begin
                rd_addr <= '0;
                rd_wrap <= ~rd_wrap;
            end else begin
                rd_addr <= rd_addr + 1'b1;
            end
        end
    end

    // true word count; wrap bits differ when the writer is a lap ahead
    always_comb begin
        if (wr_wrap == rd_wrap) begin
            fifo_counter = {1'b0, wr_addr} - {1'b0, rd_addr};
        end else begin
            fifo_counter = CNT_BITS'(DEPTH) + {1'b0, wr_addr} - {1'b0, rd_addr};
        end
    end

    assign fifo_empty = (fifo_counter == '0);
    assign fifo_full  = (fifo_counter == CNT_BITS'(DEPTH));
    assign fifo_half  = (fifo_counter >= CNT_BITS'(DEPTH / 2));

    ////////////////////////////////////////////////////////////
    // staging and latch storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en) begin
            wr_data_q <= data_in;
            wr_row_q  <= wr_addr;
        end
        if (rd_en) begin
            rd_row_q <= rd_addr;        // row for the next data_out update
        end
    end

    gate_posedge_clk write_gate_i (
        .clk   (clk),
        .en    (wr_en),
        .enclk (wr_gclk)
    );

    gate_posedge_clk read_gate_i (
        .clk   (clk),
        .en    (rd_en),
        .enclk (rd_gclk)
    );

    // row written in the high phase after the strobe cycle
    always_latch begin
        if (wr_gclk) begin
            mem[wr_row_q] <= wr_data_q;
        end
    end

    // output latch, settled by the falling edge
    always_latch begin
        if (rd_gclk) begin
            data_out <= mem[rd_row_q];
        end
    end

endmodule

//--- gate_posedge_clk.sv
/*
 * latch based clock gate
 * enable is captured by a latch that is open while clk is low, so the
 * gated clock is a clean pulse during the high phase after enable was set
 */

`timescale 1ns/1ps

module gate_posedge_clk (
    input  logic clk,
    input  logic en,     // request a pulse in the next high phase
    output logic enclk   // gated clock
);

    logic en_lat;        // enable held through the high phase

    // transparent while clk is low, closes at the rising edge
    always_latch begin
        if (!clk) begin
            en_lat <= en;
        end
    end

    assign enclk = clk & en_lat;  // no glitch since en_lat is frozen while clk is high

endmodule

//--- readout_pkg.sv
/*
 * readout package
 * payload structs for the hit and configuration streams, the 64-bit
 * transmit word layout, packet type codes, FIFO depths and UART frame
 * constants shared by the readout blocks
 */

package readout_pkg;

    ////////////////////////////////////////////////////////////
    // payloads carried by the two FIFOs
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [5:0]  channel_id;   // pixel channel that fired
        logic [31:0] timestamp;    // hit time
        logic [7:0]  adc;          // amplitude
    } data_hit_t;                  // 46 bits

    typedef struct packed {
        logic [7:0] reg_addr;      // register that was read
        logic [7:0] reg_value;     // its contents
    } config_reply_t;              // 16 bits

    ////////////////////////////////////////////////////////////
    // transmit word, declared msb first, sent lsb first
    ////////////////////////////////////////////////////////////

    localparam int PAYLOAD_BITS = 52;  // room for the wider of the two payloads

    typedef struct packed {
        logic                    parity;    // makes the 64-bit weight odd
        logic                    reserved;  // always 0
        logic [PAYLOAD_BITS-1:0] payload;   // right aligned, zero padded
        logic [7:0]              chip_id;
        logic [1:0]              pkt_type;
    } tx_word_t;

    localparam logic [1:0] PKT_DATA   = 2'b01;
    localparam logic [1:0] PKT_CONFIG = 2'b10;

    // fifo sizing
    localparam int DATA_FIFO_DEPTH   = 8;
    localparam int CONFIG_FIFO_DEPTH = 4;
    localparam int DATA_CNT_BITS     = $clog2(DATA_FIFO_DEPTH) + 1;  // counts 0..DEPTH

    // uart frame: start + 64 data + stop
    localparam int FRAME_BITS     = 66;
    localparam int FRAME_CNT_BITS = $clog2(FRAME_BITS);

endpackage
